// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench.
# Any variable below can be set on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TB PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
src/mem_pkg.sv
src/memory_arbiter.sv
src/wait_state_ram.sv
src/mem_subsystem_top.sv
dv/mem_subsystem_properties.sv
dv/tb_mem_subsystem.sv

// ==== dv/mem_subsystem_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_properties (
  input logic              CLK,
  input logic              nRST,
  input mem_pkg::bus_req_t i_ibus_req,
  input mem_pkg::bus_req_t i_dbus_req,
  input mem_pkg::bus_rsp_t i_ibus_rsp,
  input mem_pkg::bus_rsp_t i_dbus_rsp,
  input mem_pkg::bus_req_t i_mem_req, // arbiter to ram.
  input mem_pkg::bus_rsp_t i_mem_rsp  // ram to arbiter.
);

  logic mem_active; // a request is on the memory bus.

  assign mem_active = i_mem_req.ren | i_mem_req.wen;

  // a port only completes a transfer it asked for.
  ibus_done_has_req: assert property (@(posedge CLK) disable iff (!nRST)
    !i_ibus_rsp.busy |-> i_ibus_req.ren)
    else $error("fetch port completed with no fetch pending");

  dbus_done_has_req: assert property (@(posedge CLK) disable iff (!nRST)
    !i_dbus_rsp.busy |-> (i_dbus_req.ren || i_dbus_req.wen))
    else $error("data port completed with no access pending");

  // the ram counts wait states on a held request.
  mem_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_active && i_mem_rsp.busy) |=> $stable(i_mem_req))
    else $error("memory request changed before the ram answered");

  mem_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
    !(i_mem_req.ren && i_mem_req.wen))
    else $error("read and write strobes both set on the memory bus");

endmodule

bind mem_subsystem_top mem_subsystem_properties mem_subsystem_properties_inst (
  .CLK        (CLK),
  .nRST       (nRST),
  .i_ibus_req (i_ibus_req),
  .i_dbus_req (i_dbus_req),
  .i_ibus_rsp (o_ibus_rsp),
  .i_dbus_rsp (o_dbus_rsp),
  .i_mem_req  (mem_req),
  .i_mem_rsp  (mem_rsp)
);

`default_nettype wire

// ==== dv/tb_mem_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsystem;
  import mem_pkg::*;

  localparam endian_t BUS_ENDIAN    = ENDIAN_LITTLE; // same as the DUT defaults.
  localparam int      RAM_LATENCY   = 2;
  localparam int      RAM_WORDS     = 256;
  localparam int      CLK_PERIOD    = 40;
  localparam int      ADDR_WINDOW   = 8;   // words, kept small so accesses collide.
  localparam int      RANDOM_TXNS   = 600;
  localparam int      DIRECTED_TXNS = 40;  // rough count of the directed accesses.
  localparam longint  WATCHDOG_NS   = longint'(RANDOM_TXNS + DIRECTED_TXNS)
                                      * (2 * RAM_LATENCY + 4) * CLK_PERIOD;

  logic     CLK = 1'b0;
  logic     nRST;
  bus_req_t ibus_req;
  bus_req_t dbus_req;
  bus_rsp_t ibus_rsp;
  bus_rsp_t dbus_rsp;

  word_t       model_mem [RAM_WORDS]; // reference contents, memory lane order.
  int unsigned lcg_state = 48;
  int          cycle;                 // negedge count, for completion order.
  int          d_done_cycle;
  int          i_done_cycle;
  logic        d_busy_seen;           // busy levels sampled in the last cycle.
  logic        i_busy_seen;
  logic        d_free;                // port may take a new request now.
  logic        i_free;

  mem_subsystem_top mem_subsystem_top_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .i_ibus_req (ibus_req),
    .i_dbus_req (dbus_req),
    .o_ibus_rsp (ibus_rsp),
    .o_dbus_rsp (dbus_rsp)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16; // low bits of an lcg repeat quickly.
  endfunction

  function automatic word_t random_word();
    word_t w;
    w[31:16] = 16'(lcg_next());
    w[15:0]  = 16'(lcg_next());
    return w;
  endfunction

  function automatic addr_t random_addr();
    return addr_t'((lcg_next() % ADDR_WINDOW) * 4);
  endfunction

  // core byte order to bus lanes and back, the reversal is its own inverse.
  function automatic word_t reorder_bytes(word_t w);
    word_t r;
    r = w;
    if (BUS_ENDIAN == ENDIAN_LITTLE) begin
      for (int b = 0; b < 4; b++) r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  function automatic int word_index(addr_t a);
    return int'((a >> 2) % RAM_WORDS);
  endfunction

  function automatic word_t model_read(addr_t a);
    return reorder_bytes(model_mem[word_index(a)]);
  endfunction

  // byte enables name bus lanes, so the data is reordered first.
  task automatic model_write(addr_t a, word_t d, byte_en_t be);
    word_t lanes;
    lanes = reorder_bytes(d);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) model_mem[word_index(a)][8*b +: 8] = lanes[8*b +: 8];
    end
  endtask

  task automatic fail_run(string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                         $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED time=%0t signal=%s expected=%b actual=%b",
                         $time, name, expected, actual));
    end
  endtask

  // one clock. outputs sampled at the falling edge, inputs driven at the rising one.
  task automatic tick();
    logic d_pend;
    logic i_pend;
    @(negedge CLK);
    cycle++;
    d_pend      = dbus_req.ren | dbus_req.wen;
    i_pend      = ibus_req.ren;
    d_busy_seen = dbus_rsp.busy;
    i_busy_seen = ibus_rsp.busy;
    if (!d_pend) begin
      check_bit("o_dbus_rsp.busy", 1'b1, d_busy_seen); // idle port never completes.
    end else if (!d_busy_seen) begin
      d_done_cycle = cycle;
      if (dbus_req.wen) model_write(dbus_req.addr, dbus_req.wdata, dbus_req.byte_en);
      else check_word("o_dbus_rsp.rdata", model_read(dbus_req.addr), dbus_rsp.rdata);
    end
    if (!i_pend) begin
      check_bit("o_ibus_rsp.busy", 1'b1, i_busy_seen); // covers withdrawn fetches too.
    end else if (!i_busy_seen) begin
      i_done_cycle = cycle;
      check_word("o_ibus_rsp.rdata", model_read(ibus_req.addr), ibus_rsp.rdata);
    end
    d_free = !d_pend || !d_busy_seen;
    i_free = !i_pend || !i_busy_seen;
    @(posedge CLK);
    if (d_free) dbus_req <= '0; // a new request may override this.
    if (i_free) ibus_req <= '0;
  endtask

  task automatic issue_data(logic write, addr_t a, word_t d, byte_en_t be);
    bus_req_t r;
    r.ren     = ~write;
    r.wen     = write;
    r.addr    = a;
    r.wdata   = d;
    r.byte_en = be;
    dbus_req <= r;
  endtask

  task automatic issue_random_data();
    issue_data(1'(lcg_next() & 1), random_addr(), random_word(), byte_en_t'(lcg_next()));
  endtask

  task automatic issue_fetch(addr_t a);
    bus_req_t r;
    r.ren     = 1'b1;
    r.wen     = 1'b0;
    r.addr    = a;
    r.wdata   = '0;
    r.byte_en = '1;
    ibus_req <= r;
  endtask

  task automatic wait_idle();
    do begin
      tick();
    end while (!(d_free && i_free));
  endtask

  // lone access, busy must drop exactly RAM_LATENCY + 1 cycles after the arbiter sees it.
  task automatic lone_access(logic fetch, addr_t a);
    string name;
    name = fetch ? "o_ibus_rsp.busy" : "o_dbus_rsp.busy";
    if (fetch) issue_fetch(a);
    else issue_data(1'b0, a, '0, '0);
    for (int k = 1; k <= RAM_LATENCY + 2; k++) begin
      tick();
      check_bit(name, k != RAM_LATENCY + 2, fetch ? i_busy_seen : d_busy_seen);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_run("no completion arrived before the watchdog expired");
  end

  initial begin
    addr_t a;
    int    issued;
    nRST     <= 1'b0;
    ibus_req <= '0;
    dbus_req <= '0;
    for (int i = 0; i < RAM_WORDS; i++) model_mem[i] = '0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    repeat (4) tick(); // both ports idle and busy.
    lone_access(1'b0, 32'h190); // untouched words read as zero.
    lone_access(1'b1, 32'h194);
    repeat (8) begin // partial writes, read back on both ports.
      a = random_addr();
      issue_data(1'b1, a, random_word(), byte_en_t'(lcg_next()));
      wait_idle();
      issue_data(1'b0, a, '0, '0);
      wait_idle();
      issue_fetch(a);
      wait_idle();
    end
    repeat (4) begin // same-cycle requests, data goes first.
      issue_random_data();
      issue_fetch(random_addr());
      wait_idle();
      if (i_done_cycle < d_done_cycle) fail_run("fetch completed before the competing data access");
    end
    a = random_addr();
    issue_data(1'b1, a, random_word(), 4'hf);
    issue_fetch(a);
    tick();
    tick(); // fetch is queued behind the write now.
    ibus_req <= '0;
    wait_idle();
    issue_fetch(a);
    wait_idle();
    issued = 0;
    while (issued < RANDOM_TXNS) begin
      tick();
      if (d_free && (lcg_next() % 4) != 0) begin
        issue_random_data();
        issued++;
      end
      if (i_free && issued < RANDOM_TXNS && (lcg_next() % 4) != 0) begin
        issue_fetch(random_addr());
        issued++;
      end
    end
    wait_idle();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int WORD_BYTES = 4; // byte lanes per bus word.

  typedef logic [31:0] word_t; // one data word.
  typedef logic [31:0] addr_t; // byte address, word index is addr >> 2.
  typedef logic [WORD_BYTES-1:0] byte_en_t; // one bit per memory-bus lane, lane 0 is bits 7:0.

  // request as driven by a core port or by the arbiter onto the memory bus.
  typedef struct packed {
    logic     ren;     // read strobe.
    logic     wen;     // write strobe.
    addr_t    addr;    // byte address.
    word_t    wdata;   // write data.
    byte_en_t byte_en; // lanes to write.
  } bus_req_t;

  // response back to a requester.
  typedef struct packed {
    logic  busy;  // low for the one cycle in which the transfer completes.
    word_t rdata; // valid in the completion cycle of a read.
  } bus_rsp_t;

  // byte order of the core.
  typedef enum logic {
    ENDIAN_BIG,
    ENDIAN_LITTLE
  } endian_t;

endpackage

`default_nettype wire

// ==== src/mem_subsystem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top #(
  parameter mem_pkg::endian_t BUS_ENDIAN  = mem_pkg::ENDIAN_LITTLE, // core byte order.
  parameter int               RAM_LATENCY = 2,
  parameter int               RAM_WORDS   = 256
) (
  input  logic              CLK,
  input  logic              nRST,
  input  mem_pkg::bus_req_t i_ibus_req, // instruction fetch port.
  input  mem_pkg::bus_req_t i_dbus_req, // data port.
  output mem_pkg::bus_rsp_t o_ibus_rsp,
  output mem_pkg::bus_rsp_t o_dbus_rsp
);
  import mem_pkg::*;

  bus_req_t mem_req; // arbiter to ram.
  bus_rsp_t mem_rsp; // ram to arbiter.

  memory_arbiter #(
    .BUS_ENDIAN (BUS_ENDIAN)
  ) memory_arbiter_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .i_ibus_req (i_ibus_req),
    .i_dbus_req (i_dbus_req),
    .o_ibus_rsp (o_ibus_rsp),
    .o_dbus_rsp (o_dbus_rsp),
    .o_mem_req  (mem_req),
    .i_mem_rsp  (mem_rsp)
  );

  wait_state_ram #(
    .RAM_LATENCY (RAM_LATENCY),
    .RAM_WORDS   (RAM_WORDS)
  ) wait_state_ram_inst (
    .CLK       (CLK),
    .nRST      (nRST),
    .i_mem_req (mem_req),
    .o_mem_rsp (mem_rsp)
  );

endmodule

`default_nettype wire

// ==== src/memory_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_arbiter #(
  parameter mem_pkg::endian_t BUS_ENDIAN = mem_pkg::ENDIAN_LITTLE
) (
  input  logic              CLK,
  input  logic              nRST,
  input  mem_pkg::bus_req_t i_ibus_req, // fetch port, read only.
  input  mem_pkg::bus_req_t i_dbus_req, // data port.
  output mem_pkg::bus_rsp_t o_ibus_rsp,
  output mem_pkg::bus_rsp_t o_dbus_rsp,
  output mem_pkg::bus_req_t o_mem_req,  // shared memory bus.
  input  mem_pkg::bus_rsp_t i_mem_rsp
);
  import mem_pkg::*;

  // *_REQ is the first bus cycle of a grant, *_WAIT the rest of it.
  // the paired states hold a second request queued behind the granted one.
  typedef enum logic [2:0] {
    IDLE,
    INSTR_REQ,      // fetch on the bus, first cycle.
    INSTR_DATA_REQ, // fetch on the bus, data queued.
    INSTR_WAIT,     // fetch on the bus, waiting for memory.
    DATA_REQ,       // data on the bus, first cycle.
    DATA_INSTR_REQ, // data on the bus, fetch queued.
    DATA_WAIT       // data on the bus, waiting for memory.
  } arb_state_t;

  arb_state_t state, next_state;

  bus_req_t instr_mem_req; // fetch as presented to memory.
  bus_req_t data_mem_req;  // data access as presented to memory.
  word_t    mem_wdata;     // data port write data in memory byte order.
  word_t    core_rdata;    // memory read data in core byte order.
  logic     d_pending;     // data port asks for a transfer.
  logic     i_pending;     // fetch port asks for a transfer.
  logic     mem_done;      // memory completes the granted transfer this cycle.
  logic     ibus_busy;
  logic     dbus_busy;

  assign d_pending = i_dbus_req.ren | i_dbus_req.wen;
  assign i_pending = i_ibus_req.ren; // fetch port never writes.
  assign mem_done  = ~i_mem_rsp.busy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // next state.
  // a fetch that drops ren is withdrawn. the queued data access, if any, goes next.
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (d_pending) next_state = DATA_REQ; // data wins ties.
        else if (i_pending) next_state = INSTR_REQ;
      end
      INSTR_REQ: begin
        if (!i_pending) next_state = d_pending ? DATA_REQ : IDLE; // abort.
        else if (d_pending) next_state = INSTR_DATA_REQ;
        else next_state = INSTR_WAIT;
      end
      INSTR_DATA_REQ: begin
        if (mem_done) next_state = DATA_WAIT; // queued data goes on the bus next.
        else if (!i_pending) next_state = DATA_REQ; // fetch withdrawn on the bus.
      end
      INSTR_WAIT: begin
        if (mem_done || !i_pending) next_state = d_pending ? DATA_REQ : IDLE;
        else if (d_pending) next_state = INSTR_DATA_REQ;
      end
      DATA_REQ: begin
        next_state = i_pending ? DATA_INSTR_REQ : DATA_WAIT;
      end
      DATA_INSTR_REQ: begin
        if (mem_done) next_state = i_pending ? INSTR_WAIT : IDLE; // skip a dropped fetch.
        else if (!i_pending) next_state = DATA_WAIT; // queued fetch withdrawn.
      end
      DATA_WAIT: begin
        if (mem_done) next_state = i_pending ? INSTR_REQ : IDLE;
        else if (i_pending) next_state = DATA_INSTR_REQ;
      end
      default: next_state = IDLE;
    endcase
  end

  // fetch is forced to a full-word read.
  always_comb begin
    instr_mem_req         = i_ibus_req;
    instr_mem_req.wen     = 1'b0;
    instr_mem_req.wdata   = '0;
    instr_mem_req.byte_en = '1;
  end

  always_comb begin
    data_mem_req       = i_dbus_req;
    data_mem_req.wdata = mem_wdata; // byte enables stay as given, they name bus lanes.
  end

  // bus select and port busy. the granted request stays on the bus in every state
  // of its grant so that memory sees it stable.
  always_comb begin
    o_mem_req = '0; // idle bus.
    ibus_busy = 1'b1;
    dbus_busy = 1'b1;
    case (state)
      INSTR_REQ: begin
        o_mem_req = instr_mem_req; // first bus cycle, no completion yet.
      end
      INSTR_DATA_REQ, INSTR_WAIT: begin
        o_mem_req = instr_mem_req;
        ibus_busy = i_mem_rsp.busy;
      end
      DATA_REQ: begin
        o_mem_req = data_mem_req;
      end
      DATA_INSTR_REQ, DATA_WAIT: begin
        o_mem_req = data_mem_req;
        dbus_busy = i_mem_rsp.busy;
      end
      default: begin
        o_mem_req = '0;
      end
    endcase
  end

  // byte order between the core and the memory bus.
  generate
    if (BUS_ENDIAN == ENDIAN_LITTLE) begin : g_swap
      assign mem_wdata  = {i_dbus_req.wdata[7:0], i_dbus_req.wdata[15:8],
                           i_dbus_req.wdata[23:16], i_dbus_req.wdata[31:24]};
      assign core_rdata = {i_mem_rsp.rdata[7:0], i_mem_rsp.rdata[15:8],
                           i_mem_rsp.rdata[23:16], i_mem_rsp.rdata[31:24]};
    end else begin : g_pass
      assign mem_wdata  = i_dbus_req.wdata; // big-endian core matches the bus.
      assign core_rdata = i_mem_rsp.rdata;
    end
  endgenerate

  // both ports see the read data, only the one whose busy drops takes it.
  assign o_ibus_rsp = '{busy: ibus_busy, rdata: core_rdata};
  assign o_dbus_rsp = '{busy: dbus_busy, rdata: core_rdata};

endmodule

`default_nettype wire

// ==== src/wait_state_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module wait_state_ram #(
  parameter int RAM_LATENCY = 2,  // wait cycles before completion, at least 1.
  parameter int RAM_WORDS   = 256 // power of two, at least 2.
) (
  input  logic              CLK,
  input  logic              nRST,
  input  mem_pkg::bus_req_t i_mem_req,
  output mem_pkg::bus_rsp_t o_mem_rsp
);
  import mem_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);
  localparam int ADDR_LSB = $clog2(WORD_BYTES); // byte offset bits within a word.

  typedef logic [IDX_W-1:0] word_idx_t;
  typedef logic [CNT_W-1:0] wait_cnt_t;

  word_t     mem [RAM_WORDS]; // storage array.
  wait_cnt_t wait_cnt;        // cycles the current request has been held.
  word_idx_t word_idx;
  logic      req_active;
  logic      done;            // completion cycle.

  assign req_active = i_mem_req.ren | i_mem_req.wen;
  assign word_idx   = i_mem_req.addr[ADDR_LSB +: IDX_W]; // low word-address bits.

  // completes once the request has been held for RAM_LATENCY earlier cycles.
  assign done = req_active && (wait_cnt == wait_cnt_t'(RAM_LATENCY));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (done || !req_active) begin
      wait_cnt <= '0; // restart for the next request.
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // write on the completion cycle, enabled lanes only.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0; // memory comes up as all zeros.
      end
    end else if (done && i_mem_req.wen) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (i_mem_req.byte_en[b]) begin
          mem[word_idx][8*b +: 8] <= i_mem_req.wdata[8*b +: 8];
        end
      end
    end
  end

  // whole word read, driven only in the completion cycle.
  always_comb begin
    o_mem_rsp.busy  = ~done;
    o_mem_rsp.rdata = (done && i_mem_req.ren) ? mem[word_idx] : '0;
  end

endmodule

`default_nettype wire
